/* source/noc_pkg.sv */
package noc_pkg;

	localparam int GRID_X  = 4;                  // Columns, x wraps east/west
	localparam int GRID_Y  = 3;                  // Rows, y wraps north/south
	localparam int NODES   = GRID_X * GRID_Y;    // One router per node
	localparam int COORD_W = 2;                  // Wide enough for either axis
	localparam int DATA_W  = 16;                 // Payload bits per flit
	localparam int CNT_W   = 10;                 // Receive counter width
	localparam int PORTS   = 5;                  // Local plus four directions

	typedef logic [COORD_W-1:0] coord_t;        // Single grid coordinate
	typedef logic [CNT_W-1:0]   cnt_t;          // Delivered flit count, wraps

	// Port order is also the index into every five-wide port array
	typedef enum logic [2:0] {
		PORT_LOCAL = 3'd0,                       // Injection and ejection
		PORT_EAST  = 3'd1,                       // Toward x + 1
		PORT_WEST  = 3'd2,                       // Toward x - 1
		PORT_NORTH = 3'd3,                       // Toward y + 1
		PORT_SOUTH = 3'd4                        // Toward y - 1
	} port_e;

	typedef struct packed {
		coord_t            dst_x;                // Routing target column
		coord_t            dst_y;                // Routing target row
		coord_t            src_x;                // Sender column, carried only
		coord_t            src_y;                // Sender row, carried only
		logic [DATA_W-1:0] payload;
	} flit_t;                                    // 24 bits

	typedef struct packed {
		logic  valid;                            // Qualifies flit
		flit_t flit;
	} link_t;                                    // 25 bits, ready travels apart

	// Node index x + y * GRID_X, coordinates wrap so x - 1 and x + 1 are legal
	function automatic int node_id(input int x, input int y);
		node_id = (x + GRID_X) % GRID_X + ((y + GRID_Y) % GRID_Y) * GRID_X;
	endfunction

endpackage

/* source/input_buffer.sv */
`timescale 1ns/1ps

module input_buffer
(
	input  logic           clk,
	input  logic           rst,
	input  noc_pkg::link_t in_link,        // From neighbour or injection
	output logic           in_ready,       // Space left, state only
	output noc_pkg::link_t head,           // Oldest flit toward route logic
	input  logic           pop             // Head granted this cycle
);

	noc_pkg::flit_t mem [2];               // Two flit slots
	logic           rd_ptr;                // Slot of head
	logic           wr_ptr;                // Next slot to fill
	logic [1:0]     count;                 // Occupancy 0..2
	logic           push;
	logic           take;

	assign in_ready   = (count != 2'd2);      // Never looks at valid
	assign push       = in_link.valid && in_ready;
	assign take       = pop && (count != 2'd0);   // Ignore pop when empty
	assign head.valid = (count != 2'd0);
	assign head.flit  = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in_link.flit;    // Payload storage
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_ptr <= 1'b0;
			wr_ptr <= 1'b0;
			count  <= 2'd0;                 // Empty, so ready after reset
		end
		else
		begin
			if (push)
				wr_ptr <= ~wr_ptr;          // Two entries, pointer just toggles
			if (take)
				rd_ptr <= ~rd_ptr;
			case ({push, take})
				2'b10:   count <= count + 2'd1;
				2'b01:   count <= count - 2'd1;
				default: count <= count;    // Both or neither, level unchanged
			endcase
		end
	end

endmodule

/* source/output_arbiter.sv */
`timescale 1ns/1ps

module output_arbiter
(
	input  logic                                clk,
	input  logic                                rst,
	input  logic [noc_pkg::PORTS-1:0]           req,        // One bit per input
	input  noc_pkg::flit_t [noc_pkg::PORTS-1:0] cand,       // Head flits of all inputs
	output logic [noc_pkg::PORTS-1:0]           grant,      // Pops the winner
	output noc_pkg::link_t                      out_link,   // Output register
	input  logic                                out_ready   // Downstream space
);

	logic [2:0] ptr;                       // Highest priority input
	logic [2:0] win;                       // First requester from ptr
	logic       hit;                       // Any request at all
	logic       can_load;                  // Register free this edge

	assign can_load = !out_link.valid || out_ready;   // Empty or draining

	// Scan five inputs starting at the pointer
	always_comb
	begin
		int idx;
		idx = 0;
		win = ptr;
		hit = 1'b0;
		for (int i = 0; i < noc_pkg::PORTS; i++)
		begin
			idx = (int'(ptr) + i) % noc_pkg::PORTS;
			if (!hit && req[idx])
			begin
				hit = 1'b1;
				win = 3'(idx);
			end
		end
	end

	always_comb
	begin
		grant = '0;
		if (hit && can_load)
			grant[win] = 1'b1;             // Nothing granted under back-pressure
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ptr            <= noc_pkg::PORT_LOCAL;   // Local first after reset
			out_link.valid <= 1'b0;
		end
		else if (can_load)
		begin
			out_link.valid <= hit;           // Drops to empty when nobody asks
			if (hit)
			begin
				out_link.flit <= cand[win];
				ptr <= (win == 3'(noc_pkg::PORTS - 1)) ? 3'd0 : win + 3'd1;   // Past winner
			end
		end
	end

endmodule

/* source/router.sv */
`timescale 1ns/1ps

module router
#(
	parameter noc_pkg::coord_t MY_X = '0,      // Own column
	parameter noc_pkg::coord_t MY_Y = '0       // Own row
)
(
	input  logic                                clk,
	input  logic                                rst,
	input  noc_pkg::link_t [noc_pkg::PORTS-1:0] in_links,     // Indexed by port_e
	output logic [noc_pkg::PORTS-1:0]           in_readys,
	output noc_pkg::link_t [noc_pkg::PORTS-1:0] out_links,
	input  logic [noc_pkg::PORTS-1:0]           out_readys,
	output noc_pkg::cnt_t                       receive_cnt   // Flits ejected here
);

	noc_pkg::link_t [noc_pkg::PORTS-1:0] heads;    // Buffer heads
	noc_pkg::flit_t [noc_pkg::PORTS-1:0] cand;     // Same flits, valid stripped
	noc_pkg::port_e                      dir  [noc_pkg::PORTS];   // Chosen output per input
	logic [noc_pkg::PORTS-1:0]           req  [noc_pkg::PORTS];   // Per output, bit per input
	logic [noc_pkg::PORTS-1:0]           grant [noc_pkg::PORTS];  // Per output, bit per input
	logic [noc_pkg::PORTS-1:0]           pop;                     // Per input

	// Forward distance around a ring of the given size
	function automatic int ring_fwd(input int dst, input int own, input int size);
		ring_fwd = (dst - own + size) % size;
	endfunction

	// X then Y, shorter way around, tie goes east or north
	function automatic noc_pkg::port_e route(input noc_pkg::flit_t f);
		int dx;
		int dy;
		dx = ring_fwd(int'(f.dst_x), int'(MY_X), noc_pkg::GRID_X);
		dy = ring_fwd(int'(f.dst_y), int'(MY_Y), noc_pkg::GRID_Y);
		if (dx != 0)
			route = (dx <= noc_pkg::GRID_X / 2) ? noc_pkg::PORT_EAST : noc_pkg::PORT_WEST;
		else if (dy != 0)
			route = (dy <= noc_pkg::GRID_Y / 2) ? noc_pkg::PORT_NORTH : noc_pkg::PORT_SOUTH;
		else
			route = noc_pkg::PORT_LOCAL;   // Arrived
	endfunction

	always_comb
	begin
		for (int i = 0; i < noc_pkg::PORTS; i++)
			dir[i] = route(heads[i].flit);   // Don't care when head empty
	end

	// One-hot request from each valid head toward its output
	always_comb
	begin
		for (int o = 0; o < noc_pkg::PORTS; o++)
		begin
			for (int i = 0; i < noc_pkg::PORTS; i++)
				req[o][i] = heads[i].valid && (int'(dir[i]) == o);
		end
	end

	// An input asks one output only, so OR of grants is its pop
	always_comb
	begin
		pop = '0;
		for (int o = 0; o < noc_pkg::PORTS; o++)
			pop = pop | grant[o];
	end

	for (genvar p = 0; p < noc_pkg::PORTS; p++)
	begin : g_port
		assign cand[p] = heads[p].flit;

		input_buffer i_input_buffer
		(
			.clk      (clk),
			.rst      (rst),
			.in_link  (in_links[p]),
			.in_ready (in_readys[p]),
			.head     (heads[p]),
			.pop      (pop[p])
		);

		output_arbiter i_output_arbiter
		(
			.clk       (clk),
			.rst       (rst),
			.req       (req[p]),
			.cand      (cand),
			.grant     (grant[p]),
			.out_link  (out_links[p]),
			.out_ready (out_readys[p] || (p == noc_pkg::PORT_LOCAL))   // Sink always takes
		);
	end

	// Count ejected flits, wraps at CNT_W bits
	always_ff @(posedge clk)
	begin
		if (rst)
			receive_cnt <= '0;
		else if (out_links[noc_pkg::PORT_LOCAL].valid)
			receive_cnt <= receive_cnt + 1'b1;   // Register empties every cycle
	end

endmodule

/* source/torus_noc.sv */
`timescale 1ns/1ps

module torus_noc
(
	input  logic                     clk,
	input  logic                     rst,
	input  noc_pkg::link_t           inject       [noc_pkg::NODES],   // Per node, x + y * GRID_X
	output logic [noc_pkg::NODES-1:0] inject_ready,
	output noc_pkg::link_t           eject        [noc_pkg::NODES],   // No ready, sink always takes
	output noc_pkg::cnt_t            receive_cnt  [noc_pkg::NODES]
);

	noc_pkg::link_t [noc_pkg::PORTS-1:0] r_in   [noc_pkg::NODES];   // Router inputs
	noc_pkg::link_t [noc_pkg::PORTS-1:0] r_out  [noc_pkg::NODES];   // Router outputs
	logic [noc_pkg::PORTS-1:0]           r_irdy [noc_pkg::NODES];   // Input buffer space
	logic [noc_pkg::PORTS-1:0]           r_ordy [noc_pkg::NODES];   // Downstream space

	for (genvar y = 0; y < noc_pkg::GRID_Y; y++)
	begin : g_row
		for (genvar x = 0; x < noc_pkg::GRID_X; x++)
		begin : g_col
			// Local channel to the top level
			assign r_in[noc_pkg::node_id(x, y)][noc_pkg::PORT_LOCAL] =
				inject[noc_pkg::node_id(x, y)];
			assign inject_ready[noc_pkg::node_id(x, y)] =
				r_irdy[noc_pkg::node_id(x, y)][noc_pkg::PORT_LOCAL];
			assign eject[noc_pkg::node_id(x, y)] =
				r_out[noc_pkg::node_id(x, y)][noc_pkg::PORT_LOCAL];
			assign r_ordy[noc_pkg::node_id(x, y)][noc_pkg::PORT_LOCAL] = 1'b1;

			// East input comes from the east neighbour's west output, wraps at column 0
			assign r_in[noc_pkg::node_id(x, y)][noc_pkg::PORT_EAST] =
				r_out[noc_pkg::node_id(x + 1, y)][noc_pkg::PORT_WEST];
			assign r_in[noc_pkg::node_id(x, y)][noc_pkg::PORT_WEST] =
				r_out[noc_pkg::node_id(x - 1, y)][noc_pkg::PORT_EAST];
			assign r_in[noc_pkg::node_id(x, y)][noc_pkg::PORT_NORTH] =
				r_out[noc_pkg::node_id(x, y + 1)][noc_pkg::PORT_SOUTH];
			assign r_in[noc_pkg::node_id(x, y)][noc_pkg::PORT_SOUTH] =
				r_out[noc_pkg::node_id(x, y - 1)][noc_pkg::PORT_NORTH];

			// Ready runs back along the same link
			assign r_ordy[noc_pkg::node_id(x, y)][noc_pkg::PORT_EAST] =
				r_irdy[noc_pkg::node_id(x + 1, y)][noc_pkg::PORT_WEST];
			assign r_ordy[noc_pkg::node_id(x, y)][noc_pkg::PORT_WEST] =
				r_irdy[noc_pkg::node_id(x - 1, y)][noc_pkg::PORT_EAST];
			assign r_ordy[noc_pkg::node_id(x, y)][noc_pkg::PORT_NORTH] =
				r_irdy[noc_pkg::node_id(x, y + 1)][noc_pkg::PORT_SOUTH];
			assign r_ordy[noc_pkg::node_id(x, y)][noc_pkg::PORT_SOUTH] =
				r_irdy[noc_pkg::node_id(x, y - 1)][noc_pkg::PORT_NORTH];

			router
			#(
				.MY_X (noc_pkg::coord_t'(x)),
				.MY_Y (noc_pkg::coord_t'(y))
			)
			i_router
			(
				.clk         (clk),
				.rst         (rst),
				.in_links    (r_in[noc_pkg::node_id(x, y)]),
				.in_readys   (r_irdy[noc_pkg::node_id(x, y)]),
				.out_links   (r_out[noc_pkg::node_id(x, y)]),
				.out_readys  (r_ordy[noc_pkg::node_id(x, y)]),
				.receive_cnt (receive_cnt[noc_pkg::node_id(x, y)])
			);
		end
	end

endmodule

/* verif/tb_torus_noc.sv */
`timescale 1ns/1ps

module tb_torus_noc;

	localparam int TABLE_LEN   = 17;                  // Rows in stim
	localparam int RAND_FLITS  = 200;                 // Random phase length
	localparam int MAX_FLIGHT  = 8;                   // Per source cap
	localparam int HOT_NODE    = 5;                   // x 1, y 1
	localparam int TOTAL_PKTS  = TABLE_LEN + noc_pkg::NODES + RAND_FLITS;
	localparam int CYCLE_LIMIT = 40 * TOTAL_PKTS + 200;
	localparam int FLIT_W      = $bits(noc_pkg::flit_t);

	typedef struct packed {
		logic [3:0]                src;               // Injecting node index
		noc_pkg::coord_t           dst_x;
		noc_pkg::coord_t           dst_y;
		logic [noc_pkg::DATA_W-1:0] payload;
	} row_t;

	logic                             clk;
	logic                             rst;
	noc_pkg::link_t                   inject       [noc_pkg::NODES];
	logic [noc_pkg::NODES-1:0]        inject_ready;
	noc_pkg::link_t                   eject        [noc_pkg::NODES];
	noc_pkg::cnt_t                    receive_cnt  [noc_pkg::NODES];

	int sb [bit [FLIT_W-1:0]];                          // Outstanding flits, keyed by whole flit
	int exp_rx    [noc_pkg::NODES];                     // Flits sent to each node since reset
	int in_flight [noc_pkg::NODES];                     // Per source, not yet ejected
	int outstanding = 0;
	int cycles      = 0;
	int err_value   = 0;
	int err_unexp   = 0;
	int err_missing = 0;
	int seed        = 92296;

	// Node 0 to all others, then wrap edges and one local row
	row_t stim [TABLE_LEN] = '{
		'{4'd0,  2'd1, 2'd0, 16'h0101},
		'{4'd0,  2'd2, 2'd0, 16'h0102},
		'{4'd0,  2'd3, 2'd0, 16'h0103},
		'{4'd0,  2'd0, 2'd1, 16'h0104},
		'{4'd0,  2'd1, 2'd1, 16'h0105},
		'{4'd0,  2'd2, 2'd1, 16'h0106},
		'{4'd0,  2'd3, 2'd1, 16'h0107},
		'{4'd0,  2'd0, 2'd2, 16'h0108},
		'{4'd0,  2'd1, 2'd2, 16'h0109},
		'{4'd0,  2'd2, 2'd2, 16'h010a},
		'{4'd0,  2'd3, 2'd2, 16'h010b},
		'{4'd0,  2'd3, 2'd0, 16'h0230},            // West across x wrap
		'{4'd3,  2'd0, 2'd0, 16'h0203},            // East across x wrap
		'{4'd0,  2'd0, 2'd2, 16'h0220},            // South across y wrap
		'{4'd8,  2'd0, 2'd0, 16'h0208},            // North across y wrap
		'{4'd11, 2'd0, 2'd0, 16'h020b},            // Both wraps
		'{4'd6,  2'd2, 2'd1, 16'h0266}             // Source is destination
	};

	torus_noc i_torus_noc
	(
		.clk          (clk),
		.rst          (rst),
		.inject       (inject),
		.inject_ready (inject_ready),
		.eject        (eject),
		.receive_cnt  (receive_cnt)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;                     // 40 ns period
	end

	function automatic noc_pkg::flit_t make_flit(input int src, input int dx, input int dy,
		input logic [noc_pkg::DATA_W-1:0] payload);
		noc_pkg::flit_t f;
		f.dst_x   = noc_pkg::coord_t'(dx);
		f.dst_y   = noc_pkg::coord_t'(dy);
		f.src_x   = noc_pkg::coord_t'(src % noc_pkg::GRID_X);   // Index rule x + y * GRID_X
		f.src_y   = noc_pkg::coord_t'(src / noc_pkg::GRID_X);
		f.payload = payload;
		return f;
	endfunction

	task automatic add_expected(input noc_pkg::flit_t f);
		bit [FLIT_W-1:0] key;
		int dst;
		int src;
		key = f;
		dst = int'(f.dst_x) + int'(f.dst_y) * noc_pkg::GRID_X;
		src = int'(f.src_x) + int'(f.src_y) * noc_pkg::GRID_X;
		if (sb.exists(key))
			sb[key] = sb[key] + 1;                  // Same flit twice is legal in random traffic
		else
			sb[key] = 1;
		exp_rx[dst]    = exp_rx[dst] + 1;
		in_flight[src] = in_flight[src] + 1;
		outstanding    = outstanding + 1;
	endtask

	// Checks one ejected flit against its node and the scoreboard
	task automatic check_eject(input int node, input noc_pkg::flit_t f);
		bit [FLIT_W-1:0] key;
		int dst;
		int src;
		key = f;
		dst = int'(f.dst_x) + int'(f.dst_y) * noc_pkg::GRID_X;
		src = int'(f.src_x) + int'(f.src_y) * noc_pkg::GRID_X;
		if (dst != node)
		begin
			$display("ERR %0t eject[%0d] node: expected %0d, got %0d", $time, node, dst, node);
			err_value = err_value + 1;
		end
		if (sb.exists(key))
		begin
			sb[key] = sb[key] - 1;
			if (sb[key] == 0)
				sb.delete(key);
			outstanding    = outstanding - 1;
			in_flight[src] = in_flight[src] - 1;
		end
		else
		begin
			$display("Unexpected flit at node %0d at %0t: dst (%0d,%0d) src (%0d,%0d) payload %h",
				node, $time, f.dst_x, f.dst_y, f.src_x, f.src_y, f.payload);
			err_unexp = err_unexp + 1;
		end
	endtask

	// Sample ejections mid-cycle, away from the driving edge
	always @(negedge clk)
	begin
		if (!rst)
		begin
			for (int n = 0; n < noc_pkg::NODES; n++)
			begin
				if (eject[n].valid)
					check_eject(n, eject[n].flit);
			end
		end
	end

	// Lists every flit still held in the scoreboard
	task automatic report_missing();
		noc_pkg::flit_t f;
		foreach (sb[k])
		begin
			f = noc_pkg::flit_t'(k);
			$display("Missing flit: dst (%0d,%0d) src (%0d,%0d) payload %h, %0d copies never arrived",
				f.dst_x, f.dst_y, f.src_x, f.src_y, f.payload, sb[k]);
			err_missing = err_missing + sb[k];
		end
	endtask

	// Watchdog
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, %0d flits never arrived", cycles, outstanding);
			report_missing();
			$display("Errors: %0d wrong value, %0d unexpected, %0d missing",
				err_value, err_unexp, err_missing);
			$display("Finished with errors");
			$finish;
		end
	end

	// Lets receive_cnt catch up, then parks on a falling edge
	task automatic settle();
		@(posedge clk);
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic wait_drain();
		while (outstanding != 0)
			@(posedge clk);
		settle();
	endtask

	task automatic check_idle();
		for (int n = 0; n < noc_pkg::NODES; n++)
		begin
			if (inject_ready[n] !== 1'b1)
			begin
				$display("ERR %0t inject_ready[%0d]: expected 1, got %b", $time, n, inject_ready[n]);
				err_value = err_value + 1;
			end
			if (eject[n].valid !== 1'b0)
			begin
				$display("ERR %0t eject[%0d].valid: expected 0, got %b", $time, n, eject[n].valid);
				err_value = err_value + 1;
			end
			if (receive_cnt[n] !== '0)
			begin
				$display("ERR %0t receive_cnt[%0d]: expected 0, got %0d", $time, n, receive_cnt[n]);
				err_value = err_value + 1;
			end
		end
	endtask

	task automatic check_counts();
		noc_pkg::cnt_t want;
		for (int n = 0; n < noc_pkg::NODES; n++)
		begin
			want = noc_pkg::cnt_t'(exp_rx[n]);      // Counter wraps at CNT_W bits
			if (receive_cnt[n] !== want)
			begin
				$display("ERR %0t receive_cnt[%0d]: expected %0d, got %0d",
					$time, n, want, receive_cnt[n]);
				err_value = err_value + 1;
			end
		end
	endtask

	// One flit, held until the local buffer takes it
	task automatic send_row(input row_t row);
		noc_pkg::link_t l;
		int src;
		src    = int'(row.src);
		l.valid = 1'b1;
		l.flit  = make_flit(src, int'(row.dst_x), int'(row.dst_y), row.payload);
		@(posedge clk);
		inject[src] <= l;
		add_expected(l.flit);
		@(posedge clk);
		while (!inject_ready[src])
			@(posedge clk);
		inject[src].valid <= 1'b0;                  // Transfer happened on this edge
	endtask

	// All nodes fire at one node in the same cycle
	task automatic hotspot_burst(input int hot);
		noc_pkg::link_t            l;
		logic [noc_pkg::NODES-1:0] holding;
		noc_pkg::cnt_t             base;
		base = noc_pkg::cnt_t'(exp_rx[hot]);        // Deliveries so far
		@(posedge clk);
		for (int n = 0; n < noc_pkg::NODES; n++)
		begin
			l.valid = 1'b1;
			l.flit  = make_flit(n, hot % noc_pkg::GRID_X, hot / noc_pkg::GRID_X, 16'ha000 + 16'(n));
			inject[n] <= l;
			add_expected(l.flit);
		end
		holding = '1;
		while (holding != '0)
		begin
			@(posedge clk);
			for (int n = 0; n < noc_pkg::NODES; n++)
			begin
				if (holding[n] && inject_ready[n])
				begin
					holding[n] = 1'b0;
					inject[n].valid <= 1'b0;
				end
			end
		end
		wait_drain();
		if (receive_cnt[hot] !== noc_pkg::cnt_t'(int'(base) + noc_pkg::NODES))
		begin
			$display("ERR %0t receive_cnt[%0d]: expected %0d, got %0d", $time, hot,
				noc_pkg::cnt_t'(int'(base) + noc_pkg::NODES), receive_cnt[hot]);
			err_value = err_value + 1;
		end
	endtask

	// One random source tries each cycle, bounded load keeps rings moving
	task automatic random_traffic();
		noc_pkg::link_t            l;
		logic [noc_pkg::NODES-1:0] holding;
		logic [31:0]               r;
		int                        sent;
		int                        src;
		holding = '0;
		sent    = 0;
		while (sent < RAND_FLITS || holding != '0)
		begin
			@(posedge clk);
			for (int n = 0; n < noc_pkg::NODES; n++)
			begin
				if (holding[n] && inject_ready[n])
				begin
					holding[n] = 1'b0;
					inject[n].valid <= 1'b0;
				end
			end
			if (sent < RAND_FLITS)
			begin
				r   = $random(seed);
				src = int'(r[15:0]) % noc_pkg::NODES;
				if (!holding[src] && in_flight[src] < MAX_FLIGHT)
				begin
					r       = $random(seed);
					l.valid = 1'b1;
					l.flit  = make_flit(src, int'(r[1:0]), int'(r[23:8]) % noc_pkg::GRID_Y,
						r[31:16]);
					inject[src] <= l;               // Overrides any drop above
					add_expected(l.flit);
					holding[src] = 1'b1;
					sent = sent + 1;
				end
			end
		end
	endtask

	initial
	begin
		rst = 1'b1;
		for (int n = 0; n < noc_pkg::NODES; n++)
		begin
			inject[n]    = '0;
			exp_rx[n]    = 0;
			in_flight[n] = 0;
		end
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_idle();

		for (int r = 0; r < TABLE_LEN; r++)
		begin
			send_row(stim[r]);
			wait_drain();                           // Strictly one at a time
		end
		check_counts();

		hotspot_burst(HOT_NODE);
		check_counts();

		random_traffic();
		wait_drain();
		check_counts();

		$display("Errors: %0d wrong value, %0d unexpected, %0d missing",
			err_value, err_unexp, err_missing);
		if (err_value + err_unexp + err_missing == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* files.f */
source/noc_pkg.sv
source/input_buffer.sv
source/output_arbiter.sv
source/router.sv
source/torus_noc.sv
verif/tb_torus_noc.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_torus_noc
FILELIST  := files.f
FLAGS     := --binary --timing -Wno-fatal
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Finished with no errors

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
